/* src/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    localparam int addr_width = 30;
    localparam int idx_width = 6;
    localparam int hist_width = 8;
    localparam int ras_depth = 8;
    localparam int ras_ptr_width = $clog2(ras_depth);
    localparam int table_depth = 2 ** idx_width;

    // two-bit counter reset value
    localparam logic [1:0] ctr_weak_nt = 2'b01;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [idx_width-1:0] idx_t;
    typedef logic [hist_width-1:0] hist_t;
    typedef logic [ras_ptr_width-1:0] ras_ptr_t;
    typedef logic [ras_ptr_width:0] ras_cnt_t;

    typedef enum logic [2:0] {
        not_jump,
        direct_jump,
        jump,
        call,
        ret,
        indirect_jump,
        other_jump
    } kind_t;

    typedef struct packed {
        addr_t npc;
        kind_t kind;
        logic taken;
        hist_t bh;
        hist_t gh;
        logic choice_dir;
        logic choice_tgt;
    } prediction_t;

    // dir_correct bit 0 local, bit 1 global; tgt_correct bit 0 btb, bit 1 ras
    typedef struct packed {
        addr_t pc;
        addr_t npc;
        addr_t ret_pc;
        kind_t kind;
        logic taken;
        hist_t bh;
        hist_t gh;
        logic choice_dir_pdc;
        logic choice_tgt_pdc;
        logic [1:0] dir_correct;
        logic [1:0] tgt_correct;
        logic mis_taken;
        logic mis_kind;
        logic mis_npc;
    } resolve_t;

    function automatic idx_t hash_pc(addr_t a);
        return a[idx_width-1:0] ^ a[2*idx_width-1:idx_width];
    endfunction

    function automatic idx_t hash_pc_hist(idx_t idx, hist_t h);
        return idx ^ h[idx_width-1:0];
    endfunction

    function automatic logic is_cond(kind_t k);
        return (k == direct_jump) || (k == other_jump);
    endfunction

    // saturating two-bit step
    function automatic logic [1:0] ctr_step(logic [1:0] ctr, logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

endpackage

`default_nettype wire

/* src/kind_table.sv */
`timescale 1ns/10ps
`default_nettype none

module kind_table (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire bp_pkg::idx_t  rd_idx,
    output bp_pkg::kind_t      kind,
    input  wire logic          update_en,
    input  wire bp_pkg::idx_t  wr_idx,
    input  wire bp_pkg::kind_t wr_kind
);

    logic [2:0] kind_mem [bp_pkg::table_depth];
    logic [2:0] kind_raw;

    assign kind_raw = kind_mem[rd_idx];

    // unused codes fall back to not_jump
    always_comb begin
        if (kind_raw > 3'(bp_pkg::other_jump)) begin
            kind = bp_pkg::not_jump;
        end else begin
            kind = bp_pkg::kind_t'(kind_raw);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::table_depth; i++) begin
                kind_mem[i] <= 3'(bp_pkg::not_jump);
            end
        end else if (update_en) begin
            kind_mem[wr_idx] <= wr_kind;
        end
    end

endmodule

`default_nettype wire

/* src/local_history_table.sv */
`timescale 1ns/10ps
`default_nettype none

module local_history_table (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire bp_pkg::idx_t  rd_idx,
    output bp_pkg::hist_t      bh,
    input  wire logic          update_en,
    input  wire bp_pkg::idx_t  wr_idx,
    input  wire bp_pkg::hist_t bh_ex,
    input  wire logic          taken
);

    bp_pkg::hist_t bh_mem [bp_pkg::table_depth];

    assign bh = bh_mem[rd_idx];

    // new history built from the snapshot carried by the resolve
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::table_depth; i++) begin
                bh_mem[i] <= '0;
            end
        end else if (update_en) begin
            bh_mem[wr_idx] <= {bh_ex[bp_pkg::hist_width-2:0], taken};
        end
    end

endmodule

`default_nettype wire

/* src/global_history.sv */
`timescale 1ns/10ps
`default_nettype none

module global_history (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          stall,
    input  wire logic          jump_pdc,
    input  wire logic          taken_pdc,
    input  wire logic          update_en,
    input  wire logic          mis_taken,
    input  wire bp_pkg::hist_t gh_ex,
    input  wire logic          taken_real,
    output bp_pkg::hist_t      gh
);

    bp_pkg::hist_t gh_q;
    logic          restore;
    logic          spec_shift;

    assign restore = update_en && mis_taken;
    assign spec_shift = !stall && jump_pdc;

    // restore from the resolve snapshot wins over the speculative shift
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh_q <= '0;
        end else if (restore) begin
            gh_q <= {gh_ex[bp_pkg::hist_width-2:0], taken_real};
        end else if (spec_shift) begin
            gh_q <= {gh_q[bp_pkg::hist_width-2:0], taken_pdc};
        end
    end

    assign gh = gh_q;

endmodule

`default_nettype wire

/* src/direction_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module direction_predictor (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire bp_pkg::addr_t    pc,
    input  wire bp_pkg::hist_t    bh,
    input  wire bp_pkg::hist_t    gh,
    input  wire bp_pkg::kind_t    kind,
    output logic                  taken,
    output logic                  choice_dir,
    input  wire logic             update_en,
    input  wire bp_pkg::resolve_t res
);

    logic [1:0] local_ctr [bp_pkg::table_depth];
    logic [1:0] global_ctr [bp_pkg::table_depth];
    logic [1:0] chooser [bp_pkg::table_depth];

    bp_pkg::idx_t pc_idx;
    bp_pkg::idx_t local_idx;
    bp_pkg::idx_t global_idx;
    bp_pkg::idx_t res_idx;
    bp_pkg::idx_t res_local_idx;
    bp_pkg::idx_t res_global_idx;
    logic         cond_taken;
    logic         train;

    assign pc_idx = bp_pkg::hash_pc(pc);
    assign local_idx = bp_pkg::hash_pc_hist(pc_idx, bh);
    assign global_idx = bp_pkg::hash_pc_hist(pc_idx, gh);

    // chooser msb set selects the global table
    assign choice_dir = chooser[pc_idx][1];
    assign cond_taken = choice_dir ? global_ctr[global_idx][1] : local_ctr[local_idx][1];

    always_comb begin
        case (kind)
            bp_pkg::direct_jump,
            bp_pkg::other_jump:    taken = cond_taken;
            bp_pkg::jump,
            bp_pkg::call,
            bp_pkg::ret,
            bp_pkg::indirect_jump: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    // training side indexed with the histories used at prediction time
    assign res_idx = bp_pkg::hash_pc(res.pc);
    assign res_local_idx = bp_pkg::hash_pc_hist(res_idx, res.bh);
    assign res_global_idx = bp_pkg::hash_pc_hist(res_idx, res.gh);
    assign train = update_en && bp_pkg::is_cond(res.kind);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::table_depth; i++) begin
                local_ctr[i] <= bp_pkg::ctr_weak_nt;
                global_ctr[i] <= bp_pkg::ctr_weak_nt;
                chooser[i] <= bp_pkg::ctr_weak_nt;
            end
        end else if (train) begin
            local_ctr[res_local_idx] <= bp_pkg::ctr_step(local_ctr[res_local_idx], res.taken);
            global_ctr[res_global_idx] <=
                bp_pkg::ctr_step(global_ctr[res_global_idx], res.taken);
            // only a disagreement says anything about which table to trust
            if (res.dir_correct == 2'b10) begin
                chooser[res_idx] <= bp_pkg::ctr_step(chooser[res_idx], 1'b1);
            end else if (res.dir_correct == 2'b01) begin
                chooser[res_idx] <= bp_pkg::ctr_step(chooser[res_idx], 1'b0);
            end
        end
    end

endmodule

`default_nettype wire

/* src/target_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module target_predictor (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire bp_pkg::addr_t    pc,
    input  wire bp_pkg::kind_t    kind,
    input  wire logic             taken,
    output bp_pkg::addr_t         npc,
    output logic                  choice_tgt,
    input  wire logic             update_en,
    input  wire bp_pkg::resolve_t res
);

    bp_pkg::addr_t btb_tgt [bp_pkg::table_depth];
    logic          btb_valid [bp_pkg::table_depth];
    logic [1:0]    chooser [bp_pkg::table_depth];
    bp_pkg::addr_t ras_mem [bp_pkg::ras_depth];

    // wr_ptr is the next free slot, the top sits just below it
    bp_pkg::ras_ptr_t wr_ptr;
    bp_pkg::ras_cnt_t ras_cnt;
    bp_pkg::ras_ptr_t top_ptr;
    bp_pkg::addr_t    ras_top;
    logic             ras_empty;
    logic             ras_full;

    bp_pkg::idx_t pc_idx;
    bp_pkg::idx_t res_idx;
    bp_pkg::addr_t seq_pc;
    logic          use_ras;
    logic          do_push;
    logic          do_pop;

    assign pc_idx = bp_pkg::hash_pc(pc);
    assign res_idx = bp_pkg::hash_pc(res.pc);
    assign seq_pc = pc + bp_pkg::addr_t'(1);

    assign top_ptr = wr_ptr - bp_pkg::ras_ptr_t'(1);
    assign ras_top = ras_mem[top_ptr];
    assign ras_empty = (ras_cnt == '0);
    assign ras_full = (ras_cnt == bp_pkg::ras_cnt_t'(bp_pkg::ras_depth));

    // chooser msb set prefers the return stack
    assign choice_tgt = chooser[pc_idx][1];
    assign use_ras = (kind == bp_pkg::ret) && choice_tgt && !ras_empty;

    always_comb begin
        if (use_ras) begin
            npc = ras_top;
        end else if (taken && btb_valid[pc_idx]) begin
            npc = btb_tgt[pc_idx];
        end else begin
            npc = seq_pc;
        end
    end

    assign do_push = update_en && (res.kind == bp_pkg::call);
    assign do_pop = update_en && (res.kind == bp_pkg::ret) && !ras_empty;

    // full stack wraps over the oldest entry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            ras_cnt <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + bp_pkg::ras_ptr_t'(1);
            if (!ras_full) begin
                ras_cnt <= ras_cnt + bp_pkg::ras_cnt_t'(1);
            end
        end else if (do_pop) begin
            wr_ptr <= top_ptr;
            ras_cnt <= ras_cnt - bp_pkg::ras_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            ras_mem[wr_ptr] <= res.ret_pc;
        end
        if (update_en && res.taken) begin
            btb_tgt[res_idx] <= res.npc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::table_depth; i++) begin
                btb_valid[i] <= 1'b0;
                chooser[i] <= bp_pkg::ctr_weak_nt;
            end
        end else if (update_en) begin
            if (res.taken) begin
                btb_valid[res_idx] <= 1'b1;
            end
            if (res.kind == bp_pkg::ret) begin
                if (res.tgt_correct == 2'b10) begin
                    chooser[res_idx] <= bp_pkg::ctr_step(chooser[res_idx], 1'b1);
                end else if (res.tgt_correct == 2'b01) begin
                    chooser[res_idx] <= bp_pkg::ctr_step(chooser[res_idx], 1'b0);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire bp_pkg::addr_t    pc,
    input  wire logic             stall,
    input  wire logic             update_en,
    input  wire bp_pkg::resolve_t res,
    output bp_pkg::prediction_t   pred
);

    bp_pkg::idx_t  pc_idx;
    bp_pkg::idx_t  res_idx;
    bp_pkg::kind_t kind_pdc;
    bp_pkg::hist_t bh_pdc;
    bp_pkg::hist_t gh_pdc;
    bp_pkg::addr_t npc_pdc;
    logic          taken_pdc;
    logic          choice_dir;
    logic          choice_tgt;
    logic          jump_pdc;
    logic          bh_update_en;

    assign pc_idx = bp_pkg::hash_pc(pc);
    assign res_idx = bp_pkg::hash_pc(res.pc);
    assign jump_pdc = (kind_pdc != bp_pkg::not_jump);
    assign bh_update_en = update_en && (res.kind != bp_pkg::not_jump);

    kind_table i_kind_table (
        .clk       (clk),
        .rstn      (rstn),
        .rd_idx    (pc_idx),
        .kind      (kind_pdc),
        .update_en (update_en),
        .wr_idx    (res_idx),
        .wr_kind   (res.kind)
    );

    local_history_table i_local_history_table (
        .clk       (clk),
        .rstn      (rstn),
        .rd_idx    (pc_idx),
        .bh        (bh_pdc),
        .update_en (bh_update_en),
        .wr_idx    (res_idx),
        .bh_ex     (res.bh),
        .taken     (res.taken)
    );

    global_history i_global_history (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .jump_pdc   (jump_pdc),
        .taken_pdc  (taken_pdc),
        .update_en  (update_en),
        .mis_taken  (res.mis_taken),
        .gh_ex      (res.gh),
        .taken_real (res.taken),
        .gh         (gh_pdc)
    );

    direction_predictor i_direction_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .bh         (bh_pdc),
        .gh         (gh_pdc),
        .kind       (kind_pdc),
        .taken      (taken_pdc),
        .choice_dir (choice_dir),
        .update_en  (update_en),
        .res        (res)
    );

    target_predictor i_target_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .kind       (kind_pdc),
        .taken      (taken_pdc),
        .npc        (npc_pdc),
        .choice_tgt (choice_tgt),
        .update_en  (update_en),
        .res        (res)
    );

    assign pred = '{
        npc:        npc_pdc,
        kind:       kind_pdc,
        taken:      taken_pdc,
        bh:         bh_pdc,
        gh:         gh_pdc,
        choice_dir: choice_dir,
        choice_tgt: choice_tgt
    };

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rstn
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // low for four cycles, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_branch_predictor;

    typedef struct packed {
        bp_pkg::addr_t    pc;
        logic             stall;
        logic             update_en;
        bp_pkg::resolve_t res;
        logic             check;
        bp_pkg::kind_t    kind;
        logic             taken;
        bp_pkg::addr_t    npc;
    } step_t;

    localparam int clk_period = 10;

    // hash_pc indexes 0x10, 0x27 and 0x2d
    localparam bp_pkg::addr_t pc_a = 30'h0000_0010;
    localparam bp_pkg::addr_t pc_b = 30'h0000_0123;
    localparam bp_pkg::addr_t pc_d = 30'h0000_0a05;
    localparam bp_pkg::addr_t tgt_a = 30'h0000_4000;
    localparam bp_pkg::addr_t tgt_t = 30'h0000_2200;
    localparam bp_pkg::addr_t tgt_t2 = 30'h0000_3300;
    localparam bp_pkg::addr_t ret_r0 = 30'h0000_0011;
    localparam bp_pkg::addr_t ret_r1 = 30'h0000_1001;
    localparam bp_pkg::addr_t ret_r2 = 30'h0000_1801;
    localparam bp_pkg::addr_t seq_b = pc_b + 30'd1;

    logic                clk;
    logic                rstn;
    bp_pkg::addr_t       pc;
    logic                stall;
    logic                update_en;
    bp_pkg::resolve_t    res;
    bp_pkg::prediction_t pred;

    step_t steps [$];
    logic  table_built;

    clock_gen i_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    branch_predictor i_branch_predictor (
        .clk       (clk),
        .rstn      (rstn),
        .pc        (pc),
        .stall     (stall),
        .update_en (update_en),
        .res       (res),
        .pred      (pred)
    );

    // histories of all ones, as repeated taken outcomes leave them
    function automatic bp_pkg::resolve_t make_res(input bp_pkg::addr_t r_pc,
                                                  input bp_pkg::addr_t r_npc,
                                                  input bp_pkg::addr_t r_ret,
                                                  input bp_pkg::kind_t r_kind,
                                                  input logic r_taken,
                                                  input logic [1:0] r_tgt_correct);
        bp_pkg::resolve_t r;
        r = '0;
        r.pc = r_pc;
        r.npc = r_npc;
        r.ret_pc = r_ret;
        r.kind = r_kind;
        r.taken = r_taken;
        r.bh = '1;
        r.gh = '1;
        r.dir_correct = 2'b11;
        r.tgt_correct = r_tgt_correct;
        return r;
    endfunction

    task automatic add_step(input bp_pkg::addr_t s_pc, input logic s_stall,
                            input logic s_upd, input bp_pkg::resolve_t s_res,
                            input logic s_check, input bp_pkg::kind_t e_kind,
                            input logic e_taken, input bp_pkg::addr_t e_npc);
        step_t s;
        s.pc = s_pc;
        s.stall = s_stall;
        s.update_en = s_upd;
        s.res = s_res;
        s.check = s_check;
        s.kind = e_kind;
        s.taken = e_taken;
        s.npc = e_npc;
        steps.push_back(s);
    endtask

    task automatic build_table();
        bp_pkg::resolve_t call_r0;
        bp_pkg::resolve_t br_t;
        bp_pkg::resolve_t br_nt;
        bp_pkg::resolve_t br_t2;
        call_r0 = make_res(pc_a, tgt_a, ret_r0, bp_pkg::call, 1'b1, 2'b01);
        br_t = make_res(pc_b, tgt_t, '0, bp_pkg::direct_jump, 1'b1, 2'b01);
        br_nt = make_res(pc_b, seq_b, '0, bp_pkg::direct_jump, 1'b0, 2'b01);
        br_t2 = make_res(pc_b, tgt_t2, '0, bp_pkg::direct_jump, 1'b1, 2'b01);
        // fresh tables fall through
        add_step(30'h0000_0005, 1'b0, 1'b0, '0, 1'b1, bp_pkg::not_jump, 1'b0, 30'h0000_0006);
        add_step(pc_b, 1'b0, 1'b0, '0, 1'b1, bp_pkg::not_jump, 1'b0, seq_b);
        add_step(30'h3fff_ffff, 1'b0, 1'b0, '0, 1'b1, bp_pkg::not_jump, 1'b0, 30'h0000_0000);
        add_step(pc_a, 1'b1, 1'b1, call_r0, 1'b1, bp_pkg::call, 1'b1, tgt_a);
        for (int n = 0; n < 3; n++) begin
            add_step(pc_b, 1'b1, 1'b0, br_t, 1'b1, bp_pkg::not_jump, 1'b0, seq_b);
        end
        for (int n = 0; n < bp_pkg::hist_width + 2; n++) begin
            add_step(pc_b, 1'b1, 1'b1, br_t, 1'b1, bp_pkg::direct_jump, 1'b1, tgt_t);
        end
        // ret at D trains its chooser toward the stack and empties it
        add_step(pc_a, 1'b1, 1'b1, make_res(pc_d, ret_r0, '0, bp_pkg::ret, 1'b1, 2'b10),
                 1'b1, bp_pkg::call, 1'b1, tgt_a);
        add_step(pc_a, 1'b1, 1'b1, make_res(pc_a, tgt_a, ret_r1, bp_pkg::call, 1'b1, 2'b01),
                 1'b1, bp_pkg::call, 1'b1, tgt_a);
        add_step(pc_a, 1'b1, 1'b1, make_res(pc_a, tgt_a, ret_r2, bp_pkg::call, 1'b1, 2'b01),
                 1'b1, bp_pkg::call, 1'b1, tgt_a);
        add_step(pc_d, 1'b0, 1'b0, '0, 1'b1, bp_pkg::ret, 1'b1, ret_r2);
        add_step(pc_d, 1'b1, 1'b1, make_res(pc_d, ret_r2, '0, bp_pkg::ret, 1'b1, 2'b10),
                 1'b1, bp_pkg::ret, 1'b1, ret_r1);
        for (int n = 0; n < bp_pkg::hist_width + 2; n++) begin
            add_step(pc_b, 1'b1, 1'b1, br_nt, 1'b1, bp_pkg::direct_jump, 1'b0, seq_b);
        end
        // counter climbs back from strongly not-taken
        add_step(pc_b, 1'b1, 1'b1, br_t2, 1'b1, bp_pkg::direct_jump, 1'b0, seq_b);
        add_step(pc_b, 1'b1, 1'b1, br_t2, 1'b1, bp_pkg::direct_jump, 1'b1, tgt_t2);
        add_step(pc_b, 1'b1, 1'b1, br_t2, 1'b1, bp_pkg::direct_jump, 1'b1, tgt_t2);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    initial begin
        pc = '0;
        stall = 1'b0;
        update_en = 1'b0;
        res = '0;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;
        wait (rstn === 1'b1);
        @(negedge clk);
        foreach (steps[i]) begin
            pc = steps[i].pc;
            stall = steps[i].stall;
            update_en = steps[i].update_en;
            res = steps[i].res;
            @(negedge clk);
            if (steps[i].check) begin
                check_value(32'(pred.kind), 32'(steps[i].kind), $sformatf("step %0d kind", i));
                check_value(32'(pred.taken), 32'(steps[i].taken),
                            $sformatf("step %0d taken", i));
                check_value(32'(pred.npc), 32'(steps[i].npc), $sformatf("step %0d npc", i));
            end
        end
        $display("all tests passed");
        $finish;
    end

    // 10 cycles per table row plus 100
    initial begin
        wait (table_built === 1'b1);
        #((steps.size() * 10 + 100) * clk_period);
        $display("timeout: the step table did not complete in the allowed time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* tb.f */
src/bp_pkg.sv
src/kind_table.sv
src/local_history_table.sv
src/global_history.sv
src/direction_predictor.sv
src/target_predictor.sv
src/branch_predictor.sv
bench/clock_gen.sv
bench/tb_branch_predictor.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f tb.f \
    --top-module tb_branch_predictor \
    -o sim_tb_branch_predictor

./obj_dir/sim_tb_branch_predictor
